/* verilog/mini_core_pkg.sv */
package mini_core_pkg;

    // **************************************************
    // sizes
    // **************************************************
    localparam int imem_depth = 64;
    localparam int dmem_depth = 16;
    localparam int num_regs   = 8;
    localparam int addr_w     = 12;
    localparam int pc_w       = $clog2(imem_depth);
    localparam int dmem_aw    = $clog2(dmem_depth);
    localparam int reg_aw     = $clog2(num_regs);

    // **************************************************
    // host address map
    // **************************************************
    localparam logic [addr_w-1:0] addr_ctrl      = 12'h000; // w: bit0 start, r: halted/busy
    localparam logic [addr_w-1:0] addr_start_pc  = 12'h004;
    localparam logic [addr_w-1:0] addr_perf_base = 12'h010; // four counters
    localparam logic [addr_w-1:0] addr_reg_base  = 12'h080; // eight registers
    localparam logic [addr_w-1:0] addr_imem_base = 12'h100; // write only

    localparam logic [1:0] axil_resp_okay   = 2'd0;
    localparam logic [1:0] axil_resp_slverr = 2'd2;

    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_and    = 4'd2,
        op_or     = 4'd3,
        op_addi   = 4'd4,
        op_ld     = 4'd5,
        op_st     = 4'd6,
        op_bnez   = 4'd7,
        op_ebreak = 4'd8   // other codes behave the same
    } opcode_e;

    // prefixed, a plain halted would clash with the status ports
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_commit,
        st_halted
    } seq_state_e;

    typedef struct packed {
        opcode_e            opcode;
        logic [reg_aw-1:0]  rd;
        logic [reg_aw-1:0]  rs1;
        logic [reg_aw-1:0]  rs2;
        logic [2:0]         spare;
        logic signed [15:0] imm;
    } instr_t;

    typedef struct packed {
        instr_t      ins;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
    } decode_t;

    typedef struct packed {
        logic              wb_en;
        logic [reg_aw-1:0] rd;
        logic [31:0]       value;
        logic              is_load;
        logic              is_store;
        logic              take_branch;
        logic [pc_w-1:0]   target;
        logic              is_halt;
    } commit_t;

    typedef struct packed {
        logic              awvalid;
        logic [addr_w-1:0] awaddr;
        logic              wvalid;
        logic [31:0]       wdata;
        logic [3:0]        wstrb;
        logic              bready;
        logic              arvalid;
        logic [addr_w-1:0] araddr;
        logic              rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [31:0] fetches;
        logic [31:0] loads;
        logic [31:0] stores;
        logic [31:0] busy_cycles;
    } perf_t;

endpackage

/* verilog/host_regs.sv */
`timescale 1ns/1ps

module host_regs import mini_core_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  axil_req_t         axil_req,
    output axil_rsp_t         axil_rsp,
    input  logic              busy,
    input  logic              halted,
    input  perf_t             perf,
    input  logic [pc_w-1:0]   fetch_pc,
    output instr_t            fetch_word,
    output logic              start,
    output logic [pc_w-1:0]   start_pc,
    output logic [reg_aw-1:0] host_reg_addr,
    input  logic [31:0]       host_reg_data
);

    logic [31:0]       imem [imem_depth];
    logic [addr_w-1:0] wa;
    logic [addr_w-1:0] ra;
    logic              wr_fire;
    logic              rd_fire;
    logic              wr_ctrl;
    logic              wr_pc;
    logic              wr_imem;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              rvalid;
    logic [1:0]        rresp;
    logic [31:0]       rdata;
    logic [31:0]       rd_value;
    logic [1:0]        rd_resp;

    assign wa = axil_req.awaddr;
    assign ra = axil_req.araddr;

    // aw and w accepted together, one outstanding response per channel
    assign wr_fire = axil_req.awvalid & axil_req.wvalid & ~bvalid;
    assign rd_fire = axil_req.arvalid & ~rvalid;

    assign wr_ctrl = (wa[addr_w-1:2] == addr_ctrl[addr_w-1:2]);
    assign wr_pc   = (wa[addr_w-1:2] == addr_start_pc[addr_w-1:2]);
    assign wr_imem = (wa[addr_w-1:8] == addr_imem_base[addr_w-1:8]);

    assign start = wr_fire & wr_ctrl & axil_req.wstrb[0] & axil_req.wdata[0] & ~busy;

    // **************************************************
    // write channel
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid   <= 1'b0;
            start_pc <= '0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (wr_pc && !busy && axil_req.wstrb[0]) begin
                    start_pc <= axil_req.wdata[pc_w-1:0];
                end
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= (wr_ctrl | wr_pc | wr_imem) ? axil_resp_okay : axil_resp_slverr;
        end
        if (wr_fire && wr_imem && !busy) begin
            for (int b = 0; b < 4; b++) begin
                if (axil_req.wstrb[b]) begin
                    imem[wa[pc_w+1:2]][8*b +: 8] <= axil_req.wdata[8*b +: 8];
                end
            end
        end
        fetch_word <= instr_t'(imem[fetch_pc]); // one cycle fetch latency
    end

    // **************************************************
    // read channel
    // **************************************************
    assign host_reg_addr = ra[reg_aw+1:2];

    always_comb begin
        rd_value = '0;
        rd_resp  = axil_resp_okay;
        if (ra[addr_w-1:2] == addr_ctrl[addr_w-1:2]) begin
            rd_value = {30'b0, halted, busy};
        end else if (ra[addr_w-1:2] == addr_start_pc[addr_w-1:2]) begin
            rd_value = {{(32-pc_w){1'b0}}, start_pc};
        end else if (ra[addr_w-1:4] == addr_perf_base[addr_w-1:4]) begin
            case (ra[3:2])
                2'd0:    rd_value = perf.fetches;
                2'd1:    rd_value = perf.loads;
                2'd2:    rd_value = perf.stores;
                default: rd_value = perf.busy_cycles;
            endcase
        end else if (ra[addr_w-1:5] == addr_reg_base[addr_w-1:5]) begin
            rd_value = host_reg_data;
        end else begin
            rd_resp = axil_resp_slverr; // imem and holes
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_value; // held until rready
            rresp <= rd_resp;
        end
    end

    assign axil_rsp.awready = wr_fire;
    assign axil_rsp.wready  = wr_fire;
    assign axil_rsp.bvalid  = bvalid;
    assign axil_rsp.bresp   = bresp;
    assign axil_rsp.arready = ~rvalid;
    assign axil_rsp.rvalid  = rvalid;
    assign axil_rsp.rdata   = rdata;
    assign axil_rsp.rresp   = rresp;

endmodule

/* verilog/core_seq.sv */
`timescale 1ns/1ps

module core_seq import mini_core_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic [pc_w-1:0]   start_pc,
    output logic [pc_w-1:0]   fetch_pc,
    input  instr_t            fetch_word,
    output logic [reg_aw-1:0] rs1_addr,
    output logic [reg_aw-1:0] rs2_addr,
    input  logic [31:0]       rs1_data,
    input  logic [31:0]       rs2_data,
    output decode_t           dec,
    input  commit_t           cmt,
    output logic              wr_en,
    output logic [reg_aw-1:0] wr_addr,
    output logic [31:0]       wr_data,
    output logic              fetch_fire,
    output logic              load_fire,
    output logic              store_fire,
    output logic              busy,
    output logic              halted,
    output logic              sim_ebreak
);

    seq_state_e      state;
    logic [pc_w-1:0] pc;
    commit_t         cmt_q;

    // **************************************************
    // sequencer
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            pc         <= '0;
            sim_ebreak <= 1'b0;
        end else begin
            sim_ebreak <= 1'b0;
            case (state)
                st_idle, st_halted: begin
                    if (start) begin
                        state <= st_fetch;
                        pc    <= start_pc;
                    end
                end
                st_fetch:   state <= st_decode;
                st_decode:  state <= st_execute;
                st_execute: state <= st_commit;
                st_commit: begin
                    if (cmt_q.is_halt) begin
                        state      <= st_halted;
                        sim_ebreak <= 1'b1; // lands with busy low
                    end else begin
                        state <= st_fetch;
                        pc    <= cmt_q.take_branch ? cmt_q.target : pc + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            dec <= {fetch_word, rs1_data, rs2_data};
        end
        if (state == st_execute) begin
            cmt_q <= cmt;
        end
    end

    assign fetch_pc = pc;
    assign rs1_addr = fetch_word.rs1; // word is valid during decode
    assign rs2_addr = fetch_word.rs2;

    assign wr_en   = (state == st_commit) & cmt_q.wb_en;
    assign wr_addr = cmt_q.rd;
    assign wr_data = cmt_q.value;

    assign fetch_fire = (state == st_fetch);
    assign load_fire  = (state == st_execute) & cmt.is_load;
    assign store_fire = (state == st_execute) & cmt.is_store; // also the dmem write strobe
    assign busy       = (state != st_idle) & (state != st_halted);
    assign halted     = (state == st_halted);

endmodule

/* verilog/perf_counters.sv */
`timescale 1ns/1ps

module perf_counters import mini_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  logic  fetch_fire,
    input  logic  load_fire,
    input  logic  store_fire,
    input  logic  busy,
    output perf_t perf
);

    // **************************************************
    // event counters, restart with every run
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset || start) begin
            perf <= '0;
        end else begin
            perf.fetches     <= perf.fetches + 32'(fetch_fire);
            perf.loads       <= perf.loads + 32'(load_fire);
            perf.stores      <= perf.stores + 32'(store_fire);
            perf.busy_cycles <= perf.busy_cycles + 32'(busy); // 4 per instr
        end
    end

endmodule

/* verilog/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import mini_core_pkg::*; (
    input  logic    clk,
    input  decode_t dec,
    input  logic    mem_we,
    output commit_t cmt
);

    logic [31:0]        dmem [dmem_depth];
    logic [31:0]        imm_sx;
    logic [31:0]        ea;
    logic [dmem_aw-1:0] mem_addr;

    assign imm_sx   = {{16{dec.ins.imm[15]}}, dec.ins.imm};
    assign ea       = dec.rs1_val + imm_sx;
    assign mem_addr = ea[dmem_aw-1:0]; // wraps mod 16

    always_ff @(posedge clk) begin
        if (mem_we) begin
            dmem[mem_addr] <= dec.rs2_val;
        end
    end

    // **************************************************
    // alu and branch resolution
    // **************************************************
    always_comb begin
        cmt             = '0;
        cmt.rd          = dec.ins.rd;
        cmt.target      = dec.ins.imm[pc_w-1:0];
        case (dec.ins.opcode)
            op_add: begin
                cmt.wb_en = 1'b1;
                cmt.value = dec.rs1_val + dec.rs2_val;
            end
            op_sub: begin
                cmt.wb_en = 1'b1;
                cmt.value = dec.rs1_val - dec.rs2_val;
            end
            op_and: begin
                cmt.wb_en = 1'b1;
                cmt.value = dec.rs1_val & dec.rs2_val;
            end
            op_or: begin
                cmt.wb_en = 1'b1;
                cmt.value = dec.rs1_val | dec.rs2_val;
            end
            op_addi: begin
                cmt.wb_en = 1'b1;
                cmt.value = dec.rs1_val + imm_sx;
            end
            op_ld: begin
                cmt.wb_en   = 1'b1;
                cmt.is_load = 1'b1;
                cmt.value   = dmem[mem_addr];
            end
            op_st: begin
                cmt.is_store = 1'b1;
            end
            op_bnez: begin
                cmt.take_branch = (dec.rs1_val != 32'd0);
            end
            default: begin
                cmt.is_halt = 1'b1; // ebreak and unknown codes
            end
        endcase
    end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file import mini_core_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [reg_aw-1:0] rs1_addr,
    input  logic [reg_aw-1:0] rs2_addr,
    output logic [31:0]       rs1_data,
    output logic [31:0]       rs2_data,
    input  logic [reg_aw-1:0] host_reg_addr,
    output logic [31:0]       host_reg_data,
    input  logic              wr_en,
    input  logic [reg_aw-1:0] wr_addr,
    input  logic [31:0]       wr_data
);

    logic [31:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin // r0 never written
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data      = regs[rs1_addr];
    assign rs2_data      = regs[rs2_addr];
    assign host_reg_data = regs[host_reg_addr];

endmodule

/* verilog/mini_core.sv */
`timescale 1ns/1ps

module mini_core import mini_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic      sim_ebreak,
    output logic      busy
);

    logic              start;
    logic [pc_w-1:0]   start_pc;
    logic [pc_w-1:0]   fetch_pc;
    instr_t            fetch_word;
    logic [reg_aw-1:0] rs1_addr;
    logic [reg_aw-1:0] rs2_addr;
    logic [31:0]       rs1_data;
    logic [31:0]       rs2_data;
    logic [reg_aw-1:0] host_reg_addr;
    logic [31:0]       host_reg_data;
    decode_t           dec;
    commit_t           cmt;
    logic              wr_en;
    logic [reg_aw-1:0] wr_addr;
    logic [31:0]       wr_data;
    logic              fetch_fire;
    logic              load_fire;
    logic              store_fire;
    logic              halted;
    perf_t             perf;

    host_regs u_host_regs (
        .clk           (clk),
        .reset         (reset),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .busy          (busy),
        .halted        (halted),
        .perf          (perf),
        .fetch_pc      (fetch_pc),
        .fetch_word    (fetch_word),
        .start         (start),
        .start_pc      (start_pc),
        .host_reg_addr (host_reg_addr),
        .host_reg_data (host_reg_data)
    );

    core_seq u_core_seq (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .start_pc   (start_pc),
        .fetch_pc   (fetch_pc),
        .fetch_word (fetch_word),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dec        (dec),
        .cmt        (cmt),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .fetch_fire (fetch_fire),
        .load_fire  (load_fire),
        .store_fire (store_fire),
        .busy       (busy),
        .halted     (halted),
        .sim_ebreak (sim_ebreak)
    );

    reg_file u_reg_file (
        .clk           (clk),
        .reset         (reset),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .host_reg_addr (host_reg_addr),
        .host_reg_data (host_reg_data),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    exec_unit u_exec_unit (
        .clk    (clk),
        .dec    (dec),
        .mem_we (store_fire), // execute-state store strobe
        .cmt    (cmt)
    );

    perf_counters u_perf_counters (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .fetch_fire (fetch_fire),
        .load_fire  (load_fire),
        .store_fire (store_fire),
        .busy       (busy),
        .perf       (perf)
    );

endmodule

/* verification/mini_core_asserts.sv */
`timescale 1ns/1ps

module mini_core_asserts import mini_core_pkg::*; (
    input logic        clk,
    input logic        reset,
    input seq_state_e  state,
    input logic        sim_ebreak,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata
);

    int err_count = 0;

    function automatic bit legal_step(input seq_state_e from, input seq_state_e to);
        case (from)
            st_idle:    return to inside {st_idle, st_fetch};
            st_fetch:   return to == st_decode;
            st_decode:  return to == st_execute;
            st_execute: return to == st_commit;
            st_commit:  return to inside {st_fetch, st_halted};
            st_halted:  return to inside {st_halted, st_fetch}; // restart
            default:    return 1'b0;
        endcase
    endfunction

    // **************************************************
    // read channel and sequencer properties
    // **************************************************
    a_read_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        $error("read response moved while rready was low");
        err_count++;
    end

    a_ebreak_pulse: assert property (@(posedge clk) disable iff (reset)
        sim_ebreak |=> !sim_ebreak)
    else begin
        $error("sim_ebreak high for more than one cycle");
        err_count++;
    end

    a_state_step: assert property (@(posedge clk) disable iff (reset)
        legal_step($past(state), state))
    else begin
        $error("illegal sequencer state transition");
        err_count++;
    end

endmodule

/* verification/mini_core_tb.sv */
`timescale 1ns/1ps

module mini_core_tb import mini_core_pkg::*; ();

    localparam int num_tests      = 6;
    localparam int planned_instr  = 9 + 9 + 20 + 10 + 6; // executed counts of tests 2 to 6
    localparam int timeout_cycles = 4 * planned_instr + 200 * num_tests;

    logic      clk;
    logic      reset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic      sim_ebreak;
    logic      busy;

    logic [31:0] lfsr = 32'h5070;
    int          cycles = 0;
    int          test_num = 1;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    // reference model state
    logic [31:0] ref_regs [num_regs];
    logic [31:0] ref_dmem [dmem_depth];
    logic [31:0] ref_imem [imem_depth];
    int          ref_count = 0;
    int          ref_loads = 0;
    int          ref_stores = 0;
    logic [31:0] prog [$];

    mini_core u_mini_core (
        .clk        (clk),
        .reset      (reset),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .sim_ebreak (sim_ebreak),
        .busy       (busy)
    );

    bind core_seq mini_core_asserts u_seq_chk (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .sim_ebreak (sim_ebreak),
        .rvalid     (1'b0),
        .rready     (1'b1),
        .rdata      (32'd0)
    );

    bind host_regs mini_core_asserts u_host_chk (
        .clk        (clk),
        .reset      (reset),
        .state      (mini_core_pkg::st_idle),
        .sim_ebreak (1'b0),
        .rvalid     (rvalid),
        .rready     (axil_req.rready),
        .rdata      (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("timeout after %0d cycles, the core or the bus stopped answering", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // **************************************************
    // helpers
    // **************************************************
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // x^32+x^22+x^2+x+1
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc(input opcode_e op, input int rd, input int rs1,
                                        input int rs2, input int imm);
        logic [31:0] w;
        w = {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000, 16'(imm)};
        return w;
    endfunction

    function automatic void set_reg(input logic [2:0] rd, input logic [31:0] val);
        if (rd != 3'd0) begin
            ref_regs[rd] = val; // r0 stays zero
        end
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %0d %s: ok", test_num, name);
            tests_passed++;
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, test_errors);
            tests_failed++;
        end
        test_num++;
        test_errors = 0;
    endtask

    task automatic run_model(input logic [pc_w-1:0] start);
        logic [pc_w-1:0] pc;
        logic [31:0]     w;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     sx;
        logic [31:0]     ea;
        bit              halt;
        pc = start;
        halt = 1'b0;
        ref_count = 0;
        ref_loads = 0;
        ref_stores = 0;
        while (!halt && ref_count < 1000) begin
            w  = ref_imem[pc];
            a  = ref_regs[w[24:22]];
            b  = ref_regs[w[21:19]];
            sx = {{16{w[15]}}, w[15:0]};
            ea = a + sx;
            ref_count++;
            pc = pc + 1'b1;
            case (w[31:28])
                op_add:  set_reg(w[27:25], a + b);
                op_sub:  set_reg(w[27:25], a - b);
                op_and:  set_reg(w[27:25], a & b);
                op_or:   set_reg(w[27:25], a | b);
                op_addi: set_reg(w[27:25], a + sx);
                op_ld: begin
                    set_reg(w[27:25], ref_dmem[ea[3:0]]); // mod 16
                    ref_loads++;
                end
                op_st: begin
                    ref_dmem[ea[3:0]] = b;
                    ref_stores++;
                end
                op_bnez: begin
                    if (a != 32'd0) begin
                        pc = w[pc_w-1:0];
                    end
                end
                default: halt = 1'b1; // ebreak counts as executed
            endcase
        end
    endtask

    // **************************************************
    // AXI4-Lite master
    // **************************************************
    task automatic axi_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        int delay;
        delay = int'(take_bits(2));
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        @(negedge clk);
        while (!axil_rsp.awready) @(negedge clk);
        check_eq("wready", 32'd1, 32'(axil_rsp.wready)); // paired with awready
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        repeat (delay) @(posedge clk); // B back-pressure
        axil_req.bready <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.bvalid) @(negedge clk);
        check_eq("bresp", 32'(exp_resp), 32'(axil_rsp.bresp));
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [addr_w-1:0] addr, input logic [1:0] exp_resp,
                            output logic [31:0] data);
        int delay;
        delay = int'(take_bits(2));
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        repeat (delay) @(posedge clk); // R back-pressure
        axil_req.rready <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.rvalid) @(negedge clk);
        data = axil_rsp.rdata;
        check_eq("rresp", 32'(exp_resp), 32'(axil_rsp.rresp));
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic load_prog(input logic [pc_w-1:0] base);
        for (int i = 0; i < prog.size(); i++) begin
            ref_imem[base + i] = prog[i];
            axi_write(addr_imem_base + 12'(4 * (base + i)), prog[i], axil_resp_okay);
        end
    endtask

    task automatic run_program(input logic [pc_w-1:0] base, input bit restart);
        logic [31:0] v;
        run_model(base);
        axi_write(addr_start_pc, 32'(base), axil_resp_okay);
        axi_write(addr_ctrl, 32'h1, axil_resp_okay);
        if (restart) begin
            axi_read(addr_perf_base, axil_resp_okay, v);
            while (v < 32'd2) axi_read(addr_perf_base, axil_resp_okay, v); // first commit done
            axi_write(addr_ctrl, 32'h1, axil_resp_okay);
        end
        @(negedge clk);
        while (busy) @(negedge clk);
        check_eq("sim_ebreak", 32'd1, 32'(sim_ebreak)); // same cycle as busy drop
    endtask

    task automatic check_regs();
        logic [31:0] v;
        for (int i = 0; i < num_regs; i++) begin
            axi_read(addr_reg_base + 12'(4 * i), axil_resp_okay, v);
            check_eq($sformatf("r%0d", i), ref_regs[i], v);
        end
    endtask

    task automatic check_perf();
        logic [31:0] v;
        logic [31:0] exp [4];
        string       names [4];
        exp[0] = 32'(ref_count);
        exp[1] = 32'(ref_loads);
        exp[2] = 32'(ref_stores);
        exp[3] = 32'(4 * ref_count);
        names  = '{"fetches", "loads", "stores", "busy_cycles"};
        for (int i = 0; i < 4; i++) begin
            axi_read(addr_perf_base + 12'(4 * i), axil_resp_okay, v);
            check_eq(names[i], exp[i], v);
        end
    endtask

    // **************************************************
    // test sequence
    // **************************************************
    initial begin
        logic [31:0] v;
        int          assert_errors;
        reset    = 1'b1;
        axil_req = '0;
        for (int i = 0; i < num_regs; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < dmem_depth; i++) begin
            ref_dmem[i] = '0;
        end
        for (int i = 0; i < imem_depth; i++) begin
            ref_imem[i] = '0;
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        axi_read(addr_ctrl, axil_resp_okay, v);
        check_eq("status", 32'h0, v);
        check_perf();
        check_regs();
        finish_test("reset values");

        prog = {enc(op_addi, 1, 0, 0, int'(take_bits(16))),
                enc(op_addi, 2, 0, 0, int'(take_bits(16))),
                enc(op_add, 3, 1, 2, 0),
                enc(op_sub, 4, 1, 2, 0),
                enc(op_and, 5, 3, 4, 0),
                enc(op_or, 6, 1, 4, 0),
                enc(op_addi, 7, 6, 0, int'(take_bits(16))),
                enc(op_addi, 0, 1, 0, int'(take_bits(16))), // r0 must ignore this
                enc(op_ebreak, 0, 0, 0, 0)};
        load_prog(0);
        run_program(0, 1'b0);
        check_regs();
        finish_test("arithmetic");

        prog = {enc(op_addi, 1, 0, 0, 20),
                enc(op_addi, 2, 0, 0, int'(take_bits(16))),
                enc(op_addi, 3, 0, 0, int'(take_bits(16))),
                enc(op_st, 0, 1, 2, 0),   // 20 wraps to 4
                enc(op_st, 0, 1, 3, -7),  // 13
                enc(op_ld, 5, 0, 0, 4),
                enc(op_ld, 6, 1, 0, 25),  // 45 wraps to 13
                enc(op_ld, 7, 1, 0, 16),  // 36 wraps to 4
                enc(op_ebreak, 0, 0, 0, 0)};
        load_prog(0);
        run_program(0, 1'b0);
        check_regs();
        check_perf();
        finish_test("load store");

        prog = {enc(op_addi, 4, 0, 0, 6),
                enc(op_addi, 4, 4, 0, -1),
                enc(op_addi, 6, 6, 0, 2),
                enc(op_bnez, 0, 4, 0, 1),
                enc(op_ebreak, 0, 0, 0, 0)};
        load_prog(0);
        run_program(0, 1'b0);
        check_perf();
        axi_read(addr_ctrl, axil_resp_okay, v);
        check_eq("status", 32'h2, v); // halted, not busy
        check_regs();
        finish_test("branch loop");

        axi_read(addr_imem_base, axil_resp_slverr, v);
        check_eq("imem rdata", 32'h0, v);
        axi_read(12'h040, axil_resp_slverr, v);
        check_eq("unmapped rdata", 32'h0, v);
        axi_write(12'h044, 32'h1234, axil_resp_slverr);
        // loop length depends on r4, so an honored restart changes the counts
        prog = {enc(op_addi, 4, 4, 0, 4),
                enc(op_addi, 4, 4, 0, -1),
                enc(op_bnez, 0, 4, 0, 17),
                enc(op_ebreak, 0, 0, 0, 0)};
        load_prog(16);
        run_program(16, 1'b1);
        check_perf();
        check_regs();
        finish_test("host protocol");

        prog = {enc(op_addi, 1, 0, 0, int'(take_bits(16))),
                enc(op_addi, 2, 1, 0, int'(take_bits(16))),
                enc(op_st, 0, 0, 2, 9),
                enc(op_ld, 3, 0, 0, 25),
                enc(op_sub, 7, 3, 1, 0),
                enc(op_ebreak, 0, 0, 0, 0)};
        load_prog(40);
        run_program(40, 1'b0);
        check_perf();
        check_regs();
        finish_test("second start");

        assert_errors = u_mini_core.u_core_seq.u_seq_chk.err_count
                      + u_mini_core.u_host_regs.u_host_chk.err_count;
        if (assert_errors != 0) begin
            $display("%0d concurrent assertion failures were reported", assert_errors);
        end
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && assert_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* mini_core.f */
verilog/mini_core_pkg.sv
verilog/host_regs.sv
verilog/core_seq.sv
verilog/perf_counters.sv
verilog/exec_unit.sv
verilog/reg_file.sv
verilog/mini_core.sv
verification/mini_core_asserts.sv
verification/mini_core_tb.sv
